/* mnist_pkg.sv */
// mnist classifier package: image geometry, class and voter counts, beat structs, lut rules
package mnist_pkg;

	// ----------------------------------------------------------------------
	// sizes
	// ----------------------------------------------------------------------

	// square binary image, pixel (r, c) sits at bit r*img_side+c
	localparam int img_side   = 28;
	localparam int img_pixels = img_side * img_side;

	// digit classes and independent voters
	localparam int num_class  = 10;
	localparam int num_voter  = 3;

	// one lut per voter and class
	localparam int lut_inputs = 6;
	localparam int lut_size   = 1 << lut_inputs;

	// user tag carried along with each image
	localparam int user_width = 8;

	// in_valid to out_valid, counted in cycles with cke high
	localparam int latency    = 6;

	// ----------------------------------------------------------------------
	// beats between the pipeline stages
	// ----------------------------------------------------------------------

	// frame gate -> lut layer
	typedef struct packed {
		logic                  valid;
		logic                  enable;
		logic [user_width-1:0] user;
		logic [img_pixels-1:0] pixels;
	} frame_beat_t;

	// lut layer -> vote counter, voter v class c at bit v*num_class+c
	typedef struct packed {
		logic                            valid;
		logic                            enable;
		logic [user_width-1:0]           user;
		logic [num_voter*num_class-1:0]  votes;
	} vote_beat_t;

	// vote counter -> argmax, enable already folded into the counts
	typedef struct packed {
		logic                       valid;
		logic [user_width-1:0]      user;
		logic [num_class-1:0][1:0]  counts;
	} count_beat_t;

	// ----------------------------------------------------------------------
	// lut generator rules
	// ----------------------------------------------------------------------

	// pixel feeding input k of the lut for voter v and class c
	function automatic int lut_addr(input int v, input int c, input int k);
		return (c * 79 + v * 263 + k * 131 + 37) % img_pixels;
	endfunction

	// truth table: majority-like threshold on the index, flipped by one index bit
	function automatic logic [lut_size-1:0] lut_table(input int v, input int c);
		logic [lut_size-1:0] truth;
		int                  ones;
		for (int i = 0; i < lut_size; i++) begin
			ones = 0;
			for (int b = 0; b < lut_inputs; b++) begin
				ones = ones + ((i >> b) & 1);
			end
			truth[i] = (ones > 3) ^ (((i >> ((c + v) % lut_inputs)) & 1) != 0);
		end
		return truth;
	endfunction

endpackage

/* frame_gate.sv */
// frame gate: border and interior reductions, then the enable decision
`timescale 1ns/10ps

module frame_gate (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                cke,
	input  logic [mnist_pkg::user_width-1:0]    in_user,
	input  logic [mnist_pkg::img_pixels-1:0]    in_data,
	input  logic                                in_valid,
	output mnist_pkg::frame_beat_t              beat
);

	// combinational reductions over the raw image
	logic border_all;
	logic border_any;
	logic inner_all;
	logic inner_any;

	// stage 0 registers
	logic                             st0_border_all;
	logic                             st0_border_any;
	logic                             st0_inner_all;
	logic                             st0_inner_any;
	logic                             st0_valid;
	logic [mnist_pkg::user_width-1:0] st0_user;
	logic [mnist_pkg::img_pixels-1:0] st0_pixels;

	// ----------------------------------------------------------------------
	// border is row or column 0 or img_side-1, everything else is interior
	// ----------------------------------------------------------------------
	always_comb begin
		border_all = 1'b1;
		border_any = 1'b0;
		inner_all  = 1'b1;
		inner_any  = 1'b0;
		for (int r = 0; r < mnist_pkg::img_side; r++) begin
			for (int c = 0; c < mnist_pkg::img_side; c++) begin
				if (r == 0 || r == mnist_pkg::img_side - 1 ||
						c == 0 || c == mnist_pkg::img_side - 1) begin
					border_all = border_all & in_data[r * mnist_pkg::img_side + c];
					border_any = border_any | in_data[r * mnist_pkg::img_side + c];
				end else begin
					inner_all = inner_all & in_data[r * mnist_pkg::img_side + c];
					inner_any = inner_any | in_data[r * mnist_pkg::img_side + c];
				end
			end
		end
	end

	// stage 0: flags registered next to the image
	always_ff @(posedge clk) begin
		if (reset) begin
			st0_valid <= 1'b0;
		end else if (cke) begin
			st0_border_all <= border_all;
			st0_border_any <= border_any;
			st0_inner_all  <= inner_all;
			st0_inner_any  <= inner_any;
			st0_valid      <= in_valid;
			st0_user       <= in_user;
			st0_pixels     <= in_data;
		end
	end

	// stage 1: blank border with ink inside, or full border with a hole inside
	always_ff @(posedge clk) begin
		if (reset) begin
			beat.valid <= 1'b0;
		end else if (cke) begin
			beat.valid  <= st0_valid;
			beat.enable <= (!st0_border_any && st0_inner_any) ||
				(st0_border_all && !st0_inner_all);
			beat.user   <= st0_user;
			beat.pixels <= st0_pixels;
		end
	end

endmodule

/* lut_layer.sv */
// lut layer: three voters of ten 6-input luts each, one register stage
`timescale 1ns/10ps

module lut_layer (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cke,
	input  mnist_pkg::frame_beat_t  in_beat,
	output mnist_pkg::vote_beat_t   out_beat
);

	// one bit per voter and class, voter-major
	logic [mnist_pkg::num_voter*mnist_pkg::num_class-1:0] votes;

	// ----------------------------------------------------------------------
	// lut array
	// ----------------------------------------------------------------------
	for (genvar v = 0; v < mnist_pkg::num_voter; v++) begin : g_voter
		for (genvar c = 0; c < mnist_pkg::num_class; c++) begin : g_class

			// fixed truth table for this voter and class
			localparam logic [mnist_pkg::lut_size-1:0] truth =
				mnist_pkg::lut_table(v, c);

			// lut index, input k is index bit k
			logic [mnist_pkg::lut_inputs-1:0] index;

			for (genvar k = 0; k < mnist_pkg::lut_inputs; k++) begin : g_input
				// scattered pixel taps
				assign index[k] = in_beat.pixels[mnist_pkg::lut_addr(v, c, k)];
			end

			// lookup
			assign votes[v * mnist_pkg::num_class + c] = truth[index];
		end
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_beat.valid <= 1'b0;
		end else if (cke) begin
			out_beat.valid  <= in_beat.valid;
			// gate decision travels on untouched
			out_beat.enable <= in_beat.enable;
			out_beat.user   <= in_beat.user;
			out_beat.votes  <= votes;
		end
	end

endmodule

/* vote_counter.sv */
// vote counter: per-class sum of the voter bits, zeroed for rejected frames
`timescale 1ns/10ps

module vote_counter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   cke,
	input  mnist_pkg::vote_beat_t  in_beat,
	output mnist_pkg::count_beat_t out_beat
);

	// per-class sums, at most 3 so 2 bits hold them
	logic [mnist_pkg::num_class-1:0][1:0] sums;

	always_comb begin
		for (int c = 0; c < mnist_pkg::num_class; c++) begin
			sums[c] = 2'd0;
			for (int v = 0; v < mnist_pkg::num_voter; v++) begin
				sums[c] = sums[c] + 2'(in_beat.votes[v * mnist_pkg::num_class + c]);
			end
		end
	end

	// ----------------------------------------------------------------------
	// register, rejected frames leave with all counts zero
	// ----------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_beat.valid <= 1'b0;
		end else if (cke) begin
			out_beat.valid <= in_beat.valid;
			out_beat.user  <= in_beat.user;
			if (in_beat.enable) begin
				out_beat.counts <= sums;
			end else begin
				out_beat.counts <= '0;
			end
		end
	end

endmodule

/* argmax_select.sv */
// argmax selector: pairwise then final max search over the class counts
`timescale 1ns/10ps

module argmax_select (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cke,
	input  mnist_pkg::count_beat_t            in_beat,
	output logic [mnist_pkg::user_width-1:0]  out_user,
	output logic [1:0]                        out_count,
	output logic [3:0]                        out_number,
	output logic                              out_valid
);

	// pair winners, combinational
	logic [mnist_pkg::num_class/2-1:0][1:0] pair_count;
	logic [mnist_pkg::num_class/2-1:0][3:0] pair_index;

	// stage 0 registers
	logic [mnist_pkg::num_class/2-1:0][1:0] st0_count;
	logic [mnist_pkg::num_class/2-1:0][3:0] st0_index;
	logic [mnist_pkg::user_width-1:0]       st0_user;
	logic                                   st0_valid;

	// final winner, combinational
	logic [1:0] best_count;
	logic [3:0] best_index;

	// ----------------------------------------------------------------------
	// stage 0: classes 2p and 2p+1
	// ----------------------------------------------------------------------
	always_comb begin
		for (int p = 0; p < mnist_pkg::num_class / 2; p++) begin
			// odd class only wins when strictly larger
			if (in_beat.counts[2 * p + 1] > in_beat.counts[2 * p]) begin
				pair_count[p] = in_beat.counts[2 * p + 1];
				pair_index[p] = 4'(2 * p + 1);
			end else begin
				pair_count[p] = in_beat.counts[2 * p];
				pair_index[p] = 4'(2 * p);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			st0_valid <= 1'b0;
		end else if (cke) begin
			st0_count <= pair_count;
			st0_index <= pair_index;
			st0_user  <= in_beat.user;
			st0_valid <= in_beat.valid;
		end
	end

	// ----------------------------------------------------------------------
	// stage 1: scan the five survivors in index order
	// ----------------------------------------------------------------------
	always_comb begin
		best_count = st0_count[0];
		best_index = st0_index[0];
		for (int p = 1; p < mnist_pkg::num_class / 2; p++) begin
			// ties keep the earlier, lower index
			if (st0_count[p] > best_count) begin
				best_count = st0_count[p];
				best_index = st0_index[p];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (cke) begin
			out_count  <= best_count;
			out_number <= best_index;
			out_user   <= st0_user;
			out_valid  <= st0_valid;
		end
	end

endmodule

/* mnist_classifier.sv */
// mnist classifier top: frame gate, lut layer, vote counter and argmax chained
`timescale 1ns/10ps

module mnist_classifier (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              cke,

	// image in, one beat per cycle at most
	input  logic [mnist_pkg::user_width-1:0]  in_user,
	input  logic [mnist_pkg::img_pixels-1:0]  in_data,
	input  logic                              in_valid,

	// classification out
	output logic [mnist_pkg::user_width-1:0]  out_user,
	output logic [1:0]                        out_count,
	output logic [3:0]                        out_number,
	output logic                              out_valid
);

	// ----------------------------------------------------------------------
	// beats between the stages
	// ----------------------------------------------------------------------
	mnist_pkg::frame_beat_t frame_beat;
	mnist_pkg::vote_beat_t  vote_beat;
	mnist_pkg::count_beat_t count_beat;

	// 2 cycles, border and interior check
	frame_gate frame_gate_i (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.in_user  (in_user),
		.in_data  (in_data),
		.in_valid (in_valid),
		.beat     (frame_beat)
	);

	// 1 cycle, 30 lut votes
	lut_layer lut_layer_i (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.in_beat  (frame_beat),
		.out_beat (vote_beat)
	);

	// 1 cycle, per-class counts
	vote_counter vote_counter_i (
		.clk      (clk),
		.reset    (reset),
		.cke      (cke),
		.in_beat  (vote_beat),
		.out_beat (count_beat)
	);

	// 2 cycles, winning class
	argmax_select argmax_select_i (
		.clk        (clk),
		.reset      (reset),
		.cke        (cke),
		.in_beat    (count_beat),
		.out_user   (out_user),
		.out_count  (out_count),
		.out_number (out_number),
		.out_valid  (out_valid)
	);

endmodule

/* mnist_classifier_checker.sv */
// classifier checker: concurrent assertions on the top-level ports, bound to the top
`timescale 1ns/10ps

module mnist_classifier_checker (
	input logic       clk,
	input logic       reset,
	input logic       cke,
	input logic       in_valid,
	input logic       out_valid,
	input logic [1:0] out_count,
	input logic [3:0] out_number
);

	// accepted beats, shifted once per enabled cycle
	logic [mnist_pkg::latency-2:0] taken;

	always_ff @(posedge clk) begin
		if (reset) begin
			taken <= '0;
		end else if (cke) begin
			taken <= {taken[mnist_pkg::latency-3:0], in_valid};
		end
	end

	// ----------------------------------------------------------------------
	// port properties
	// ----------------------------------------------------------------------
	a_valid_known: assert property (@(posedge clk) disable iff (reset)
		!$isunknown(out_valid))
		else $error("out_valid is unknown");

	a_number_range: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> (out_number < 4'd10))
		else $error("out_number out of range");

	// zero count means rejected or no votes, class 0 then
	a_zero_count: assert property (@(posedge clk) disable iff (reset)
		(out_valid && out_count == 2'd0) |-> (out_number == 4'd0))
		else $error("out_number nonzero with zero count");

	// sixth enabled edge after acceptance raises out_valid
	a_latency_hit: assert property (@(posedge clk) disable iff (reset)
		(cke && taken[mnist_pkg::latency-2]) |=> out_valid)
		else $error("out_valid missing six enabled cycles after in_valid");

	a_latency_quiet: assert property (@(posedge clk) disable iff (reset)
		(cke && !taken[mnist_pkg::latency-2]) |=> !out_valid)
		else $error("out_valid without a beat six enabled cycles earlier");

endmodule

bind mnist_classifier mnist_classifier_checker checker_i (
	.clk        (clk),
	.reset      (reset),
	.cke        (cke),
	.in_valid   (in_valid),
	.out_valid  (out_valid),
	.out_count  (out_count),
	.out_number (out_number)
);

/* mnist_classifier_tb.sv */
// classifier testbench: clock, reset, random images and cke, reference model, scoreboard
`timescale 1ns/10ps

module mnist_classifier_tb;

	// expected beat, due is the enabled-edge count where it must appear
	typedef struct packed {
		logic [mnist_pkg::user_width-1:0] user;
		logic [1:0]                       count;
		logic [3:0]                       number;
		logic [31:0]                      due;
	} expect_t;

	logic                             clk;
	logic                             reset;
	logic                             cke;
	logic [mnist_pkg::user_width-1:0] in_user;
	logic [mnist_pkg::img_pixels-1:0] in_data;
	logic                             in_valid;
	logic [mnist_pkg::user_width-1:0] out_user;
	logic [1:0]                       out_count;
	logic [3:0]                       out_number;
	logic                             out_valid;

	// scoreboard
	expect_t exp_q[$];
	integer  seed;
	int      edge_idx;
	int      accepted;
	int      cycles;

	// outputs after the previous edge, for stalls
	logic [mnist_pkg::user_width-1:0] last_user;
	logic [1:0]                       last_count;
	logic [3:0]                       last_number;
	logic                             last_valid;

	mnist_classifier mnist_classifier_i (
		.clk        (clk),
		.reset      (reset),
		.cke        (cke),
		.in_user    (in_user),
		.in_data    (in_data),
		.in_valid   (in_valid),
		.out_user   (out_user),
		.out_count  (out_count),
		.out_number (out_number),
		.out_valid  (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
			abort_run("a DUT output differs from the model");
		end
	endtask

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic expect_t model(input logic [mnist_pkg::img_pixels-1:0] img,
			input logic [mnist_pkg::user_width-1:0] user, input int due);
		expect_t                          e;
		int                               border_ones;
		int                               inner_ones;
		int                               ones;
		int                               addr;
		int                               best;
		int                               side;
		int                               counts [mnist_pkg::num_class];
		logic                             enable;
		logic [mnist_pkg::lut_inputs-1:0] idx;
		side = mnist_pkg::img_side;
		border_ones = 0;
		inner_ones = 0;
		for (int r = 0; r < side; r++) begin
			for (int c = 0; c < side; c++) begin
				if (r == 0 || r == side - 1 || c == 0 || c == side - 1) begin
					if (img[r * side + c]) border_ones++;
				end else begin
					if (img[r * side + c]) inner_ones++;
				end
			end
		end
		// 108 border pixels, 676 interior pixels
		enable = (border_ones == 0 && inner_ones > 0) ||
			(border_ones == 4 * side - 4 && inner_ones < (side - 2) * (side - 2));
		for (int c = 0; c < mnist_pkg::num_class; c++) begin
			counts[c] = 0;
			for (int v = 0; v < mnist_pkg::num_voter; v++) begin
				for (int k = 0; k < mnist_pkg::lut_inputs; k++) begin
					addr = (c * 79 + v * 263 + k * 131 + 37) % mnist_pkg::img_pixels;
					idx[k] = img[addr];
				end
				ones = 0;
				for (int b = 0; b < mnist_pkg::lut_inputs; b++) begin
					if (idx[b]) ones++;
				end
				// popcount threshold, flipped by index bit (c+v) mod 6
				if ((ones > 3) != idx[(c + v) % mnist_pkg::lut_inputs]) counts[c]++;
			end
			if (!enable) counts[c] = 0;
		end
		// strict compare, so ties stay on the lowest class
		best = 0;
		for (int c = 1; c < mnist_pkg::num_class; c++) begin
			if (counts[c] > counts[best]) best = c;
		end
		e.user = user;
		e.count = 2'(counts[best]);
		e.number = 4'(best);
		e.due = due;
		return e;
	endfunction

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	// kind 0 blank border, kind 1 full border, kind 2 all random
	task automatic make_image(input int kind, output logic [mnist_pkg::img_pixels-1:0] img);
		logic [mnist_pkg::img_pixels+31:0] raw;
		logic                              on_border;
		int                                special;
		int                                side;
		side = mnist_pkg::img_side;
		for (int w = 0; w * 32 < mnist_pkg::img_pixels; w++) begin
			raw[w * 32 +: 32] = $random(seed);
		end
		img = raw[mnist_pkg::img_pixels-1:0];
		// one framed image in eight gets a blank or full interior
		special = {$random(seed)} % 8;
		if (kind != 2) begin
			for (int r = 0; r < side; r++) begin
				for (int c = 0; c < side; c++) begin
					on_border = (r == 0) || (r == side - 1) || (c == 0) || (c == side - 1);
					if (on_border || special == 0) img[r * side + c] = (kind == 1);
				end
			end
		end
	endtask

	task automatic drive_next(input logic allow_valid);
		logic [31:0]                      word;
		logic [mnist_pkg::img_pixels-1:0] img;
		// cke low about one cycle in five
		cke = ({$random(seed)} % 5) != 0;
		in_valid = allow_valid && (({$random(seed)} % 10) < 7);
		word = $random(seed);
		in_user = word[mnist_pkg::user_width-1:0];
		make_image(accepted % 3, img);
		in_data = img;
	endtask

	// ----------------------------------------------------------------------
	// scoreboard, called just after each rising edge
	// ----------------------------------------------------------------------
	task automatic observe();
		expect_t e;
		if (cke) begin
			edge_idx++;
			if (in_valid) begin
				exp_q.push_back(model(in_data, in_user, edge_idx + mnist_pkg::latency - 1));
				accepted++;
			end
			if (out_valid) begin
				if (exp_q.size() == 0) begin
					abort_run("out_valid rose with no accepted image pending");
				end else begin
					e = exp_q.pop_front();
					check("out_valid cycle", e.due, 32'(edge_idx));
					check("out_user", 32'(e.user), 32'(out_user));
					check("out_count", 32'(e.count), 32'(out_count));
					check("out_number", 32'(e.number), 32'(out_number));
				end
			end else if (exp_q.size() > 0 && exp_q[0].due <= 32'(edge_idx)) begin
				abort_run("an accepted image did not come out after six enabled cycles");
			end
		end else begin
			// stalled edge, everything holds
			check("out_valid", 32'(last_valid), 32'(out_valid));
			check("out_user", 32'(last_user), 32'(out_user));
			check("out_count", 32'(last_count), 32'(out_count));
			check("out_number", 32'(last_number), 32'(out_number));
		end
		last_valid = out_valid;
		last_user = out_user;
		last_count = out_count;
		last_number = out_number;
	endtask

	initial begin
		seed = 32'h1506;
		reset = 1'b1;
		cke = 1'b1;
		in_valid = 1'b0;
		in_user = '0;
		in_data = '0;
		edge_idx = 0;
		accepted = 0;
		cycles = 0;

		repeat (4) begin
			@(posedge clk);
			#1;
			check("out_valid", 32'd0, 32'(out_valid));
		end
		reset = 1'b0;
		@(posedge clk);
		#1;
		check("out_valid", 32'd0, 32'(out_valid));
		last_valid = out_valid;
		last_user = out_user;
		last_count = out_count;
		last_number = out_number;

		// 300 images, then drain with stalls still on
		while (accepted < 300) begin
			if (cycles == 4000) begin
				abort_run("timed out before 300 images were accepted");
			end else begin
				cycles++;
				drive_next(1'b1);
				@(posedge clk);
				#1;
				observe();
			end
		end
		cycles = 0;
		while (exp_q.size() > 0) begin
			if (cycles == 200) begin
				abort_run("timed out draining the pipeline with beats still pending");
			end else begin
				cycles++;
				drive_next(1'b0);
				@(posedge clk);
				#1;
				observe();
			end
		end

		$display("All checks passed");
		$finish;
	end

endmodule

/* build.f */
mnist_pkg.sv
frame_gate.sv
lut_layer.sv
vote_counter.sv
argmax_select.sv
mnist_classifier.sv
mnist_classifier_checker.sv
mnist_classifier_tb.sv

/* Makefile */
# Verilator build and run of the mnist classifier testbench

VERILATOR ?= verilator
TOP       ?= mnist_classifier_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

# the run fails with the simulator's exit status
test: $(SIM_BIN)
	./$(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
